// ==== fetch_front.f ====
verilog/fetch_pkg.sv
verilog/fetch_bus_if.sv
verilog/fetch_unit.sv
verilog/fetch_queue.sv
verilog/issue_splitter.sv
verilog/fetch_front.sv
tests/fetch_front_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module fetch_front_tb -f fetch_front.f -o fetch_front_sim || exit 1
out="$(./obj_dir/fetch_front_sim)"
echo "$out"
echo "$out" | grep -qx "All tests passed" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tests/fetch_front_tb.sv ====
`timescale 1ns/1ps

module fetch_front_tb import fetch_pkg::*; ();

  localparam int fields = 8;
  localparam int max_tests = 32;
  localparam logic [6:0] op_other = 7'b0010011; // op-imm.

  logic clock;
  logic reset;
  logic trap, mret, mispredict, fence_req, pred_taken;
  logic [addr_width-1:0] mtvec, mepc, miss_addr, fence_addr, pred_addr;
  logic imem_valid, imem_fence, imem_spec, imem_ready;
  logic [addr_width-1:0] imem_addr;
  logic [packet_width-1:0] imem_rdata;
  logic issue_hold, issue_valid;
  logic [addr_width-1:0] issue_pc;
  logic [instr_width-1:0] issue_instr;
  instr_kind_t issue_kind;

  logic [31:0] vec_mem [fields*max_tests];
  logic [addr_width-1:0] pend_addr [$]; // requests in order.
  logic pend_fence [$];
  int pend_left [$];
  logic [addr_width-1:0] target;
  logic [addr_width-1:0] exp_pc;
  instr_kind_t target_kind;
  logic pulse_now; // a redirect pulse is driven this cycle.
  logic [31:0] cur_test;
  int latency;
  int error_count;
  int cycle_count;
  int cycle_limit;
  integer seed;

  fetch_front i_dut (.*);

  always #10 clock = ~clock;

  // ------------------------------
  // memory model.
  // ------------------------------
  function automatic logic [instr_width-1:0] word_at(input logic [addr_width-1:0] a);
    logic [6:0] op;
    op = op_other;
    if (a == target) begin
      case (target_kind)
        kind_branch: op = branch;
        kind_jal: op = jal;
        kind_jalr: op = jalr;
        kind_fence: op = misc_mem;
        default: op = op_other;
      endcase
    end
    return {a[24:0] ^ {a[31:25], 18'd0}, op}; // whole address folded in above the opcode.
  endfunction

  task automatic take_requests();
    if (imem_valid || imem_fence) begin
      pend_addr.push_back(imem_addr);
      pend_fence.push_back(imem_fence);
      pend_left.push_back(latency);
    end
  endtask

  // one answer per cycle, fence acks included.
  task automatic answer_memory();
    imem_ready = 1'b0;
    imem_rdata = '0;
    if (pend_left.size() > 0) begin
      pend_left[0] = pend_left[0] - 1;
      if (pend_left[0] == 0) begin
        imem_ready = 1'b1;
        if (!pend_fence[0]) begin
          imem_rdata = {word_at(pend_addr[0] + 32'd4), word_at(pend_addr[0])};
        end
        void'(pend_addr.pop_front());
        void'(pend_fence.pop_front());
        void'(pend_left.pop_front());
      end
    end
  endtask

  // winner gets the target, the others a decoy.
  function automatic logic [addr_width-1:0] redirect_addr(input int pos, input logic [4:0] mask);
    int win;
    win = -1;
    for (int i = 0; i < 5; i++) begin
      if (mask[i]) begin
        win = i;
      end
    end
    return (pos == win) ? target : target + 32'h1000 * (pos + 1);
  endfunction

  // ------------------------------
  // checks.
  // ------------------------------
  task automatic compare_addr(input string name, input logic [addr_width-1:0] got,
                              input logic [addr_width-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_instr(input string name, input logic [instr_width-1:0] got,
                               input logic [instr_width-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_kind(input string name, input instr_kind_t got, input instr_kind_t exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s is %s, expected %s", $time, name, got.name(), exp.name());
      error_count++;
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s is %b, expected %b", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic check_issue();
    compare_addr("issue_pc", issue_pc, exp_pc);
    compare_instr("issue_instr", issue_instr, word_at(exp_pc));
    compare_kind("issue_kind", issue_kind, (exp_pc == target) ? target_kind : kind_other);
    exp_pc = exp_pc + 32'd4; // next instruction in the stream.
  endtask

  // ------------------------------
  // timeout.
  // ------------------------------
  initial begin
    wait (cycle_count > cycle_limit);
    $display("timeout in test %0d after %0d cycles, too few issues seen",
             cur_test, cycle_count);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    int base;
    int checks;
    int seen;
    int cyc;
    int test_count;
    int passed;
    int errors_before;
    logic [4:0] mask;
    logic redirected;
    logic [31:0] rnd;

    clock = 1'b0;
    reset = 1'b0;
    {trap, mret, mispredict, fence_req, pred_taken} = '0;
    {mtvec, mepc, miss_addr, fence_addr, pred_addr} = '0;
    imem_ready = 1'b0;
    imem_rdata = '0;
    issue_hold = 1'b0;
    seed = 32'h9fc4_c4dc;
    error_count = 0;
    cycle_count = 0;
    passed = 0;
    target = '0;
    target_kind = kind_other;
    pulse_now = 1'b0;
    cur_test = '0;
    latency = 1;
    exp_pc = reset_vector;

    for (int i = 0; i < fields * max_tests; i++) begin
      vec_mem[i] = '1; // end marker.
    end
    $readmemh("tests/fetch_front_vectors.txt", vec_mem);
    test_count = 0;
    cycle_limit = 0;
    while (test_count < max_tests && vec_mem[test_count * fields] !== '1) begin
      base = test_count * fields;
      cycle_limit += (vec_mem[base + 6] * (vec_mem[base + 4] + 2) + vec_mem[base + 3]) * 4;
      test_count++;
    end
    if (test_count == 0) begin
      $display("no test vectors could be read");
    end

    repeat (5) @(posedge clock);
    #2;
    reset = 1'b1;

    for (int t = 0; t < test_count; t++) begin
      base = t * fields;
      cur_test = vec_mem[base];
      mask = vec_mem[base + 1][4:0];
      target = vec_mem[base + 2];
      latency = vec_mem[base + 4];
      checks = vec_mem[base + 6];
      target_kind = instr_kind_t'(vec_mem[base + 7][2:0]);
      errors_before = error_count;
      redirected = (mask == '0); // no redirect, count from the start.
      seen = 0;
      cyc = 0;
      while (seen < checks) begin
        @(negedge clock);
        take_requests();
        compare_flag("imem_spec", imem_spec, pulse_now);
        if (issue_valid) begin
          check_issue();
          if (redirected) begin
            seen++;
          end
        end
        cycle_count++;
        @(posedge clock);
        #2;
        {trap, mret, mispredict, fence_req, pred_taken} = '0;
        pulse_now = 1'b0;
        if (!redirected && cyc == vec_mem[base + 3]) begin
          {trap, mret, mispredict, fence_req, pred_taken} = mask;
          pulse_now = 1'b1;
          mtvec = redirect_addr(4, mask);
          mepc = redirect_addr(3, mask);
          miss_addr = redirect_addr(2, mask);
          fence_addr = redirect_addr(1, mask);
          pred_addr = redirect_addr(0, mask);
          exp_pc = target;
          redirected = 1'b1;
        end
        answer_memory();
        rnd = $random(seed);
        issue_hold = vec_mem[base + 5][0] && rnd[0];
        cyc++;
      end
      $display("test %0d: %0d issues checked, %0d errors", vec_mem[base], seen,
               error_count - errors_before);
      if (error_count == errors_before) begin
        passed++;
      end
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors", test_count, passed,
             test_count - passed, error_count);
    if (passed == test_count && test_count > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== tests/fetch_front_vectors.txt ====
// test mask target redirect_cycle latency hold_enable checks kind, all in hex.
// mask bits 4..0 are trap, mret, mispredict, fence, predicted branch.
00 00 00000000 00 1 0 10 0
01 10 80010000 05 1 0 10 1
02 08 80020000 03 3 0 10 2
03 04 80030000 07 2 1 0c 3
04 02 80040000 04 3 0 10 4
05 01 80050000 06 1 1 10 0
06 1f 80060000 02 2 0 0c 1
07 0f 80070000 03 4 1 0c 2
08 07 80080000 05 2 0 0c 3
09 03 80090000 01 3 1 0c 4
0a 05 800a0000 00 5 0 0c 0
0b 01 800b0000 02 6 0 10 1
0c 08 800c0000 09 5 1 10 3
0d 02 800d0000 03 4 1 10 2
0e 00 00000000 00 2 1 20 0
0f 04 800e0000 01 1 1 14 4

// ==== verilog/fetch_bus_if.sv ====
`timescale 1ns/1ps

// packet strobe bus, no handshake.
interface fetch_bus_if import fetch_pkg::*; ();

  logic valid;
  logic [addr_width-1:0] pc;
  logic [packet_width-1:0] rdata;
  logic flush; // empties everything downstream.
  logic hold;  // no valid while high.

  modport producer (
    output valid,
    output pc,
    output rdata,
    output flush,
    input hold
  );

  modport consumer (
    input valid,
    input pc,
    input rdata,
    input flush,
    output hold
  );

endinterface

// ==== verilog/fetch_front.sv ====
`timescale 1ns/1ps

module fetch_front import fetch_pkg::*; (
  input logic clock,
  input logic reset,
  input logic trap,
  input logic [addr_width-1:0] mtvec,
  input logic mret,
  input logic [addr_width-1:0] mepc,
  input logic mispredict,
  input logic [addr_width-1:0] miss_addr,
  input logic fence_req,
  input logic [addr_width-1:0] fence_addr,
  input logic pred_taken,
  input logic [addr_width-1:0] pred_addr,
  output logic imem_valid,
  output logic [addr_width-1:0] imem_addr,
  output logic imem_fence,
  output logic imem_spec,
  input logic imem_ready,
  input logic [packet_width-1:0] imem_rdata,
  input logic issue_hold,
  output logic issue_valid,
  output logic [addr_width-1:0] issue_pc,
  output logic [instr_width-1:0] issue_instr,
  output instr_kind_t issue_kind
);

  fetch_bus_if bus_fq ();
  fetch_bus_if bus_qs ();

  fetch_unit i_fetch_unit (
    .clock      (clock),
    .reset      (reset),
    .trap       (trap),
    .mret       (mret),
    .mispredict (mispredict),
    .fence_req  (fence_req),
    .pred_taken (pred_taken),
    .mtvec      (mtvec),
    .mepc       (mepc),
    .miss_addr  (miss_addr),
    .fence_addr (fence_addr),
    .pred_addr  (pred_addr),
    .imem_ready (imem_ready),
    .imem_rdata (imem_rdata),
    .imem_valid (imem_valid),
    .imem_fence (imem_fence),
    .imem_spec  (imem_spec),
    .imem_addr  (imem_addr),
    .bus        (bus_fq.producer)
  );

  fetch_queue i_fetch_queue (
    .clock    (clock),
    .reset    (reset),
    .push_bus (bus_fq.consumer),
    .pop_bus  (bus_qs.producer)
  );

  issue_splitter i_issue_splitter (
    .clock       (clock),
    .reset       (reset),
    .bus         (bus_qs.consumer),
    .issue_hold  (issue_hold),
    .issue_valid (issue_valid),
    .issue_pc    (issue_pc),
    .issue_instr (issue_instr),
    .issue_kind  (issue_kind)
  );

endmodule

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

  // ------------------------------
  // widths.
  // ------------------------------
  localparam int addr_width = 32;
  localparam int packet_width = 64;
  localparam int instr_width = 32;

  // first fetch address out of reset.
  localparam logic [addr_width-1:0] reset_vector = 32'h8000_0000;

  // ------------------------------
  // fetch queue sizing.
  // ------------------------------
  localparam int queue_depth = 4; // power of two, pointers wrap.
  localparam int queue_ptr_width = $clog2(queue_depth);
  localparam logic [queue_ptr_width:0] queue_count_full = (queue_ptr_width + 1)'(queue_depth);
  localparam logic [queue_ptr_width:0] queue_count_last =
    (queue_ptr_width + 1)'(queue_depth - 1);

  // fetch FSM.
  typedef enum logic [1:0] {
    idle = 2'd0,
    busy = 2'd1,
    ctrl = 2'd2, // stale response in flight.
    inv  = 2'd3  // waiting on invalidate.
  } fetch_state_t;

  // what the splitter reports per instruction.
  typedef enum logic [2:0] {
    kind_other  = 3'd0,
    kind_branch = 3'd1,
    kind_jal    = 3'd2,
    kind_jalr   = 3'd3,
    kind_fence  = 3'd4
  } instr_kind_t;

  // major opcodes, bits 6:0.
  typedef enum logic [6:0] {
    branch   = 7'b1100011,
    jal      = 7'b1101111,
    jalr     = 7'b1100111,
    misc_mem = 7'b0001111
  } opcode_t;

endpackage

// ==== verilog/fetch_queue.sv ====
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; (
  input logic clock,
  input logic reset,
  fetch_bus_if.consumer push_bus,
  fetch_bus_if.producer pop_bus
);

  logic [addr_width-1:0] pc_mem [queue_depth];
  logic [packet_width-1:0] data_mem [queue_depth];
  logic [queue_ptr_width-1:0] wr_ptr;
  logic [queue_ptr_width-1:0] rd_ptr;
  logic [queue_ptr_width-1:0] wr_idx;
  logic [queue_ptr_width:0] count;
  logic empty;
  logic full;
  logic push;
  logic pop;

  always_comb begin
    empty = (count == '0);
    full = (count == queue_count_full);
    push = push_bus.valid;
    pop = !empty && !pop_bus.hold && !push_bus.flush; // flushed entries never leave.
    wr_idx = push_bus.flush ? '0 : wr_ptr; // push with flush starts a new stream.
  end

  // last slot goes to the packet arriving now.
  assign push_bus.hold = full || (count == queue_count_last && push);

  assign pop_bus.valid = pop;
  assign pop_bus.pc = pc_mem[rd_ptr];
  assign pop_bus.rdata = data_mem[rd_ptr];
  assign pop_bus.flush = push_bus.flush;

  // ------------------------------
  // storage.
  // ------------------------------
  always_ff @(posedge clock) begin
    if (push) begin
      pc_mem[wr_idx] <= push_bus.pc;
      data_mem[wr_idx] <= push_bus.rdata;
    end
  end

  // ------------------------------
  // pointers.
  // ------------------------------
  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else if (push_bus.flush) begin
      rd_ptr <= '0;
      wr_ptr <= push ? queue_ptr_width'(1) : '0;
      count <= push ? (queue_ptr_width + 1)'(1) : '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + queue_ptr_width'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + queue_ptr_width'(1);
      end
      case ({push, pop})
        2'b10: count <= count + (queue_ptr_width + 1)'(1);
        2'b01: count <= count - (queue_ptr_width + 1)'(1);
        default: count <= count;
      endcase
    end
  end

  // fetch must respect hold.
  a_no_push_full: assert property (
    @(posedge clock) disable iff (!reset)
    push && !push_bus.flush |-> !full
  );

  // pointers agree with the count when popping.
  a_no_pop_empty: assert property (
    @(posedge clock) disable iff (!reset)
    pop |-> (wr_ptr != rd_ptr) || full
  );

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import fetch_pkg::*; (
  input logic clock,
  input logic reset,
  input logic trap,
  input logic mret,
  input logic mispredict,
  input logic fence_req,
  input logic pred_taken,
  input logic [addr_width-1:0] mtvec,
  input logic [addr_width-1:0] mepc,
  input logic [addr_width-1:0] miss_addr,
  input logic [addr_width-1:0] fence_addr,
  input logic [addr_width-1:0] pred_addr,
  input logic imem_ready,
  input logic [packet_width-1:0] imem_rdata,
  output logic imem_valid,
  output logic imem_fence,
  output logic imem_spec,
  output logic [addr_width-1:0] imem_addr,
  fetch_bus_if.producer bus
);

  fetch_state_t state_q;
  fetch_state_t state_next;
  logic [addr_width-1:0] pc_q; // address of outstanding or next request.
  logic [addr_width-1:0] pc_next;
  logic req_q; // data response still due.
  logic req_next;
  logic redirect;
  logic fence;
  logic resp;
  logic stall;
  logic issue;
  logic forward;

  // ------------------------------
  // next pc.
  // ------------------------------
  always_comb begin
    redirect = trap | mret | mispredict | fence_req | pred_taken;
    resp = req_q && imem_ready;
    stall = (state_q != busy) || !resp;

    fence = 1'b0;
    pc_next = pc_q;
    if (trap) begin
      pc_next = mtvec;
    end else if (mret) begin
      pc_next = mepc;
    end else if (mispredict) begin
      pc_next = miss_addr;
    end else if (fence_req) begin
      fence = 1'b1;
      pc_next = fence_addr;
    end else if (pred_taken) begin
      pc_next = pred_addr;
    end else if (!stall) begin
      pc_next = pc_q + addr_width'(8); // next packet.
    end
  end

  // ------------------------------
  // fetch FSM.
  // ------------------------------
  always_comb begin
    state_next = state_q;
    issue = 1'b0;
    forward = 1'b0;

    case (state_q)
      idle: begin
        if (fence) begin
          state_next = inv;
        end else begin
          state_next = busy;
          issue = !bus.hold;
        end
      end
      busy: begin
        forward = resp && !redirect; // old stream packet is dropped.
        if (fence) begin
          state_next = inv;
        end else if (redirect && req_q && !imem_ready) begin
          state_next = ctrl;
        end else begin
          // nothing in flight after this cycle.
          issue = !bus.hold && (resp || !req_q);
        end
      end
      ctrl: begin
        if (fence) begin
          state_next = inv;
        end else if (imem_ready) begin
          state_next = busy; // stale packet discarded here.
          issue = !bus.hold;
        end
      end
      inv: begin
        // a pending data response comes back before the invalidate ack.
        if (imem_ready && !req_q) begin
          state_next = busy;
          issue = !bus.hold;
        end
      end
      default: begin
        state_next = idle;
      end
    endcase

    req_next = issue || (req_q && !imem_ready);
  end

  assign imem_valid = issue;
  assign imem_addr = pc_next;
  assign imem_spec = redirect;
  assign imem_fence = fence && (state_q != inv);

  assign bus.valid = forward;
  assign bus.pc = pc_q;
  assign bus.rdata = imem_rdata;
  assign bus.flush = redirect;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state_q <= idle;
      pc_q <= reset_vector;
      req_q <= 1'b0;
    end else begin
      state_q <= state_next;
      pc_q <= pc_next;
      req_q <= req_next;
    end
  end

  // at most one data request outstanding.
  a_one_outstanding: assert property (
    @(posedge clock) disable iff (!reset)
    imem_valid |-> !req_q || imem_ready
  );

  // idle only in the first cycle out of reset.
  a_idle_once: assert property (
    @(posedge clock) disable iff (!reset)
    $past(reset) |-> state_q != idle
  );

endmodule

// ==== verilog/issue_splitter.sv ====
`timescale 1ns/1ps

module issue_splitter import fetch_pkg::*; (
  input logic clock,
  input logic reset,
  fetch_bus_if.consumer bus,
  input logic issue_hold,
  output logic issue_valid,
  output logic [addr_width-1:0] issue_pc,
  output logic [instr_width-1:0] issue_instr,
  output instr_kind_t issue_kind
);

  logic full_q; // packet latched.
  logic slot_q; // 0 low word, 1 high word.
  logic advance;
  logic [addr_width-1:0] pc_q;
  logic [packet_width-1:0] data_q;

  function automatic instr_kind_t classify(input logic [instr_width-1:0] word);
    instr_kind_t kind;
    case (word[6:0])
      branch: kind = kind_branch;
      jal: kind = kind_jal;
      jalr: kind = kind_jalr;
      misc_mem: kind = kind_fence;
      default: kind = kind_other;
    endcase
    return kind;
  endfunction

  always_comb begin
    advance = full_q && !issue_hold && !bus.flush;
    issue_valid = advance;
    issue_pc = slot_q ? pc_q + addr_width'(4) : pc_q;
    issue_instr = slot_q ? data_q[packet_width-1:instr_width] : data_q[instr_width-1:0];
    issue_kind = classify(issue_instr);
  end

  // free again in the cycle slot 1 goes out.
  assign bus.hold = full_q && !(slot_q && advance);

  always_ff @(posedge clock) begin
    if (!reset) begin
      full_q <= 1'b0;
      slot_q <= 1'b0;
    end else if (bus.valid) begin
      full_q <= 1'b1;
      slot_q <= 1'b0;
    end else if (bus.flush) begin
      full_q <= 1'b0; // drop half-issued packet.
      slot_q <= 1'b0;
    end else if (advance) begin
      if (slot_q) begin
        full_q <= 1'b0;
        slot_q <= 1'b0;
      end else begin
        slot_q <= 1'b1;
      end
    end
  end

  // packet payload.
  always_ff @(posedge clock) begin
    if (bus.valid) begin
      pc_q <= bus.pc;
      data_q <= bus.rdata;
    end
  end

endmodule
